// ==== issue_stage.f ====
+incdir+src
src/issue_pkg.sv
src/phys_regfile.sv
src/issue_queue.sv
src/issue_select.sv
src/issue_operand.sv
src/issue_stage.sv
verification/issue_stage_tb.sv

// ==== Makefile ====
# Verilator build and run for the issue stage testbench

VERILATOR ?= verilator
TOP       ?= issue_stage_tb
FILELIST  ?= issue_stage.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing -Wall

SRCS := $(wildcard src/*.sv src/*.svh verification/*.sv)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(BIN) | tee $(LOG)
	@grep -qx "Test OK" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== verification/issue_stage_tb.sv ====
`default_nettype none
`include "issue_cfg.svh"

module issue_stage_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import issue_pkg::*;

    localparam int TIMEOUT = 50;
    localparam int ALU1 = 1;
    localparam int BR = 2;
    localparam int ALU2 = 3;

    typedef logic [`ROB_TAG_WIDTH-1:0] rob_t;

    // rob 0 means no op in a send or expect column
    typedef struct packed {
        rob_t     send1;
        rob_t     send2;
        logic     wb_en;
        phy_tag_t wb_tag;
        logic     byp_en;
        phy_tag_t byp_tag;
        logic     flush;
        rob_t     exp1;
        rob_t     exp2;
    } row_t;

    logic              clk;
    logic              reset;
    logic              flush;
    uop_t              dec_uop1;
    uop_t              dec_uop2;
    logic              allowin;
    result_bus_t       wb1;
    result_bus_t       wb2;
    result_bus_t       alu1_bypass;
    result_bus_t       alu2_bypass;
    result_bus_t       bru_bypass;
    issue_to_execute_t exe1;
    issue_to_execute_t exe2;

    row_t        rows [$];
    rob_t        pending [$];
    uop_t        ops [32];
    data_t       shadow [`PHY_REG_NUM];
    int          issued [32];
    logic        sent [32];
    logic        cancelled [32];
    logic [31:0] lfsr;
    int          errors;
    int          checks;
    int          count_model;
    int          accepted;
    logic        flush_prev;
    logic        ok;

    issue_stage UUT (
        .clk         (clk),
        .reset       (reset),
        .flush       (flush),
        .dec_uop1    (dec_uop1),
        .dec_uop2    (dec_uop2),
        .allowin     (allowin),
        .wb1         (wb1),
        .wb2         (wb2),
        .alu1_bypass (alu1_bypass),
        .alu2_bypass (alu2_bypass),
        .bru_bypass  (bru_bypass),
        .exe1        (exe1),
        .exe2        (exe2)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hb4bcd35c) : (s >> 1);
    endfunction

    task automatic random_word(output data_t w);
        w = '0;
        for (int b = 0; b < `DATA_WIDTH; b++) begin
            w = {w[`DATA_WIDTH-2:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
    endtask

    function automatic void def_op(input rob_t rob, input int cls, input phy_tag_t s1,
                                   input logic r1, input phy_tag_t s2, input logic r2);
        uop_t u;
        u = '0;
        u.valid = 1'b1;
        u.rf_we = 1'b1;
        u.is_alu1_op = (cls == ALU1);
        u.is_br_op = (cls == BR);
        u.is_alu2_op = (cls == ALU2);
        u.phy_src1 = s1;
        u.src1_ready = r1;
        u.phy_src2 = s2;
        u.src2_ready = r2;
        // destinations sit above every tag used as a source
        u.phy_dest = phy_tag_t'(32 + int'(rob));
        u.rob_entry_num = rob;
        ops[rob] = u;
    endfunction

    function automatic void add_row(input rob_t s1, input rob_t s2, input logic wen,
                                    input phy_tag_t wtag, input logic ben, input phy_tag_t btag,
                                    input logic fl, input rob_t e1, input rob_t e2);
        rows.push_back('{s1, s2, wen, wtag, ben, btag, fl, e1, e2});
    endfunction

    // bypass first, then writeback, then the last written register value
    function automatic data_t expect_operand(input phy_tag_t tag, input row_t r,
                                             input data_t wb_data, input data_t byp_data);
        if (tag == '0) begin
            return '0;
        end
        if (r.byp_en && r.byp_tag == tag) begin
            return byp_data;
        end
        if (r.wb_en && r.wb_tag == tag) begin
            return wb_data;
        end
        return shadow[tag];
    endfunction

    function automatic void build_tables();
        def_op(1, ALU1, 1, 1, 2, 1);
        def_op(2, ALU2, 3, 1, 0, 1);
        def_op(3, ALU1, 4, 1, 1, 1);
        def_op(4, BR, 2, 1, 3, 1);
        def_op(5, ALU1, 5, 1, 0, 1);
        def_op(6, ALU2, 10, 0, 2, 1);
        def_op(7, ALU1, 1, 1, 11, 0);
        def_op(8, ALU1, 12, 0, 0, 1);
        def_op(9, ALU2, 12, 0, 0, 1);
        def_op(10, ALU1, 12, 0, 0, 1);
        def_op(11, ALU2, 12, 0, 0, 1);
        def_op(12, ALU1, 12, 0, 0, 1);
        def_op(13, BR, 12, 0, 0, 1);
        def_op(14, ALU2, 12, 0, 0, 1);
        def_op(15, ALU1, 3, 1, 0, 1);
        def_op(16, ALU2, 0, 1, 5, 1);
        def_op(17, ALU1, 13, 0, 0, 1);
        def_op(18, ALU2, 13, 0, 1, 1);
        def_op(19, ALU1, 2, 1, 0, 1);
        def_op(20, ALU1, 13, 1, 12, 1);
        def_op(21, ALU2, 4, 1, 0, 1);
        // send1 send2 wb_en wb_tag byp_en byp_tag flush exp1 exp2
        add_row(0, 0, 1, 1, 0, 0, 0, 0, 0);
        add_row(0, 0, 1, 2, 0, 0, 0, 0, 0);
        add_row(0, 0, 1, 3, 0, 0, 0, 0, 0);
        add_row(0, 0, 1, 4, 0, 0, 0, 0, 0);
        add_row(1, 2, 1, 5, 0, 0, 0, 0, 0);
        add_row(3, 4, 0, 0, 0, 0, 0, 0, 0);
        add_row(5, 0, 1, 1, 1, 1, 0, 1, 2);
        add_row(0, 0, 1, 4, 0, 0, 0, 3, 0);
        add_row(0, 0, 0, 0, 1, 3, 0, 4, 0);
        add_row(6, 7, 0, 0, 0, 0, 0, 5, 0);
        add_row(0, 0, 0, 0, 0, 0, 0, 0, 0);
        add_row(0, 0, 0, 0, 0, 0, 0, 0, 0);
        add_row(0, 0, 1, 10, 0, 0, 0, 0, 0);
        add_row(0, 0, 1, 11, 0, 0, 0, 0, 0);
        add_row(0, 0, 0, 0, 0, 0, 0, 0, 6);
        add_row(0, 0, 0, 0, 0, 0, 0, 7, 0);
        // fill the queue with waiting ops
        add_row(8, 9, 0, 0, 0, 0, 0, 0, 0);
        add_row(10, 11, 0, 0, 0, 0, 0, 0, 0);
        add_row(12, 13, 0, 0, 0, 0, 0, 0, 0);
        add_row(14, 0, 0, 0, 0, 0, 0, 0, 0);
        add_row(15, 16, 0, 0, 0, 0, 0, 0, 0);
        add_row(0, 0, 1, 12, 0, 0, 0, 0, 0);
        add_row(0, 0, 0, 0, 0, 0, 0, 0, 0);
        add_row(0, 0, 0, 0, 0, 0, 0, 8, 9);
        add_row(0, 0, 0, 0, 0, 0, 0, 10, 11);
        add_row(0, 0, 0, 0, 0, 0, 0, 12, 14);
        add_row(0, 0, 0, 0, 0, 0, 0, 13, 16);
        add_row(0, 0, 0, 0, 0, 0, 0, 15, 0);
        // ops 17 to 19 are still queued when the flush lands
        add_row(17, 18, 0, 0, 0, 0, 0, 0, 0);
        add_row(19, 0, 0, 0, 0, 0, 0, 0, 0);
        add_row(0, 0, 1, 13, 0, 0, 1, 0, 0);
        add_row(0, 0, 0, 0, 0, 0, 0, 0, 0);
        add_row(20, 21, 0, 0, 0, 0, 0, 0, 0);
        add_row(0, 0, 0, 0, 0, 0, 0, 0, 0);
        add_row(0, 0, 0, 0, 1, 4, 0, 20, 21);
        add_row(0, 0, 0, 0, 0, 0, 0, 0, 0);
    endfunction

    task automatic check_lane(input string name, input issue_to_execute_t e, input rob_t exp,
                              input row_t r, input data_t wb_data, input data_t byp_data);
        uop_t  u;
        data_t v1;
        data_t v2;
        checks++;
        if (exp == '0 && e.valid !== 1'b0) begin
            errors++;
            $display("FAILED %s.valid expected 0x0 got 0x%h", name, e.valid);
        end else if (exp != '0 && e.valid !== 1'b1) begin
            errors++;
            $display("FAILED %s.valid expected 0x1 got 0x%h", name, e.valid);
        end else if (exp != '0 && e.rob_entry_num !== exp) begin
            errors++;
            $display("FAILED %s.rob_entry_num expected 0x%h got 0x%h", name, exp,
                     e.rob_entry_num);
        end
        if (e.valid === 1'b1) begin
            issued[e.rob_entry_num]++;
            if (!sent[e.rob_entry_num] || cancelled[e.rob_entry_num]) begin
                errors++;
                $display("op %0d issued on %s though it was never live in the queue",
                         e.rob_entry_num, name);
            end
        end
        if (exp != '0 && e.valid === 1'b1) begin
            u = ops[exp];
            if (e.rf_we !== u.rf_we) begin
                errors++;
                $display("FAILED %s.rf_we expected 0x%h got 0x%h", name, u.rf_we, e.rf_we);
            end
            if ({e.is_alu1_op, e.is_br_op, e.is_alu2_op}
                    !== {u.is_alu1_op, u.is_br_op, u.is_alu2_op}) begin
                errors++;
                $display("FAILED %s.is_alu1_op/is_br_op/is_alu2_op expected 0x%h got 0x%h",
                         name, {u.is_alu1_op, u.is_br_op, u.is_alu2_op},
                         {e.is_alu1_op, e.is_br_op, e.is_alu2_op});
            end
            if (e.phy_dest !== u.phy_dest) begin
                errors++;
                $display("FAILED %s.phy_dest expected 0x%h got 0x%h", name, u.phy_dest,
                         e.phy_dest);
            end
            v1 = expect_operand(u.phy_src1, r, wb_data, byp_data);
            v2 = expect_operand(u.phy_src2, r, wb_data, byp_data);
            if (e.src1_value !== v1) begin
                errors++;
                $display("FAILED %s.src1_value expected 0x%h got 0x%h", name, v1, e.src1_value);
            end
            if (e.src2_value !== v2) begin
                errors++;
                $display("FAILED %s.src2_value expected 0x%h got 0x%h", name, v2, e.src2_value);
            end
        end
    endtask

    task automatic run_row(input row_t r, input int idx);
        data_t       wb_data;
        data_t       byp_data;
        logic        exp_allowin;
        result_bus_t wb_bus;
        result_bus_t byp_bus;
        wb_data = '0;
        byp_data = '0;
        if (r.wb_en) begin
            random_word(wb_data);
        end
        if (r.byp_en) begin
            random_word(byp_data);
        end
        wb_bus = '{rf_we: r.wb_en, dest: r.wb_tag, result: wb_data};
        byp_bus = '{rf_we: r.byp_en, dest: r.byp_tag, result: byp_data};
        if (r.send1 != '0) begin
            pending.push_back(r.send1);
        end
        if (r.send2 != '0) begin
            pending.push_back(r.send2);
        end
        if (r.flush) begin
            pending.delete();
        end
        @(posedge clk);
        flush <= r.flush;
        wb1 <= '0;
        wb2 <= '0;
        alu1_bypass <= '0;
        alu2_bypass <= '0;
        bru_bypass <= '0;
        // spread the row's writeback and bypass over every bus
        if (idx % 2 == 0) begin
            wb1 <= wb_bus;
        end else begin
            wb2 <= wb_bus;
        end
        case (idx % 3)
            0: alu1_bypass <= byp_bus;
            1: alu2_bypass <= byp_bus;
            default: bru_bypass <= byp_bus;
        endcase
        dec_uop1 <= (pending.size() > 0) ? ops[pending[0]] : '0;
        dec_uop2 <= (pending.size() > 1) ? ops[pending[1]] : '0;
        @(negedge clk);
        // occupancy after the edge that opened this cycle
        if (flush_prev) begin
            count_model = 0;
        end else begin
            count_model = count_model + accepted - int'(r.exp1 != '0) - int'(r.exp2 != '0);
        end
        exp_allowin = (count_model <= `ISSUE_QUEUE_SIZE - 2);
        checks++;
        if (allowin !== exp_allowin) begin
            errors++;
            $display("FAILED allowin expected 0x%h got 0x%h", exp_allowin, allowin);
        end
        check_lane("exe1", exe1, r.exp1, r, wb_data, byp_data);
        check_lane("exe2", exe2, r.exp2, r, wb_data, byp_data);
        // offered ops go in at the next edge only while allowin is high
        accepted = 0;
        if (allowin === 1'b1) begin
            while (accepted < 2 && pending.size() > 0) begin
                sent[pending[0]] = 1'b1;
                void'(pending.pop_front());
                accepted++;
            end
        end
        if (r.wb_en && r.wb_tag != '0) begin
            shadow[r.wb_tag] = wb_data;
        end
        if (r.flush) begin
            for (int i = 0; i < 32; i++) begin
                cancelled[i] = sent[i] && issued[i] == 0;
            end
        end
        flush_prev = r.flush;
    endtask

    task automatic wait_allowin(output logic done);
        done = 1'b0;
        for (int n = 0; n < TIMEOUT && !done; n++) begin
            @(negedge clk);
            done = (allowin === 1'b1);
        end
        if (!done) begin
            errors++;
            $display("allowin never went high after reset");
        end
    endtask

    task automatic wait_drain(output logic done);
        int left;
        done = 1'b0;
        for (int n = 0; n < TIMEOUT && !done; n++) begin
            left = pending.size();
            for (int i = 0; i < 32; i++) begin
                left += int'(sent[i] && !cancelled[i] && issued[i] == 0);
            end
            done = (left == 0);
            if (!done) begin
                @(negedge clk);
                if (exe1.valid === 1'b1) begin
                    issued[exe1.rob_entry_num]++;
                end
                if (exe2.valid === 1'b1) begin
                    issued[exe2.rob_entry_num]++;
                end
            end
        end
        if (!done) begin
            errors++;
            $display("queued ops were still waiting to issue after %0d cycles", TIMEOUT);
        end
    endtask

    initial begin
        reset = 1'b1;
        flush = 1'b0;
        dec_uop1 = '0;
        dec_uop2 = '0;
        wb1 = '0;
        wb2 = '0;
        alu1_bypass = '0;
        alu2_bypass = '0;
        bru_bypass = '0;
        lfsr = 32'hf0af37e8;
        errors = 0;
        checks = 0;
        count_model = 0;
        accepted = 0;
        flush_prev = 1'b0;
        for (int i = 0; i < 32; i++) begin
            issued[i] = 0;
            sent[i] = 1'b0;
            cancelled[i] = 1'b0;
        end
        build_tables();
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        wait_allowin(ok);
        if (ok) begin
            checks++;
            if (exe1.valid !== 1'b0 || exe2.valid !== 1'b0) begin
                errors++;
                $display("FAILED {exe1.valid,exe2.valid} expected 0x0 got 0x%h",
                         {exe1.valid, exe2.valid});
            end
            foreach (rows[i]) begin
                run_row(rows[i], i);
            end
            wait_drain(ok);
            for (int i = 1; i < 32; i++) begin
                if (sent[i] && !cancelled[i] && issued[i] != 1) begin
                    errors++;
                    $display("op %0d issued %0d times instead of once", i, issued[i]);
                end
            end
        end
        $display("checks: %0d errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== src/issue_stage.sv ====
`default_nettype none
`include "issue_cfg.svh"

module issue_stage (
    input  wire                                clk,
    input  wire                                reset,
    input  wire                                flush,
    input  wire  issue_pkg::uop_t              dec_uop1,
    input  wire  issue_pkg::uop_t              dec_uop2,
    output logic                               allowin,
    input  wire  issue_pkg::result_bus_t       wb1,
    input  wire  issue_pkg::result_bus_t       wb2,
    input  wire  issue_pkg::result_bus_t       alu1_bypass,
    input  wire  issue_pkg::result_bus_t       alu2_bypass,
    input  wire  issue_pkg::result_bus_t       bru_bypass,
    output issue_pkg::issue_to_execute_t       exe1,
    output issue_pkg::issue_to_execute_t       exe2
);
    import issue_pkg::*;

    uop_t [`ISSUE_QUEUE_SIZE-1:0] entries;
    select_t     sel1;
    select_t     sel2;
    uop_t        pick1;
    uop_t        pick2;
    issued_tag_t iss_tag1;
    issued_tag_t iss_tag2;

    issue_queue u_queue (
        .clk      (clk),
        .reset    (reset),
        .flush    (flush),
        .dec_uop1 (dec_uop1),
        .dec_uop2 (dec_uop2),
        .sel1     (sel1),
        .sel2     (sel2),
        .iss_tag1 (iss_tag1),
        .iss_tag2 (iss_tag2),
        .wb1      (wb1),
        .wb2      (wb2),
        .allowin  (allowin),
        .entries  (entries),
        .pick1    (pick1),
        .pick2    (pick2)
    );

    issue_select u_select (
        .entries (entries),
        .sel1    (sel1),
        .sel2    (sel2)
    );

    issue_operand u_operand (
        .clk         (clk),
        .reset       (reset),
        .flush       (flush),
        .pick1       (pick1),
        .pick2       (pick2),
        .wb1         (wb1),
        .wb2         (wb2),
        .alu1_bypass (alu1_bypass),
        .alu2_bypass (alu2_bypass),
        .bru_bypass  (bru_bypass),
        .iss_tag1    (iss_tag1),
        .iss_tag2    (iss_tag2),
        .exe1        (exe1),
        .exe2        (exe2)
    );

endmodule

`default_nettype wire

// ==== src/issue_operand.sv ====
`default_nettype none
`include "issue_cfg.svh"

module issue_operand (
    input  wire                                clk,
    input  wire                                reset,
    input  wire                                flush,
    input  wire  issue_pkg::uop_t              pick1,
    input  wire  issue_pkg::uop_t              pick2,
    input  wire  issue_pkg::result_bus_t       wb1,
    input  wire  issue_pkg::result_bus_t       wb2,
    input  wire  issue_pkg::result_bus_t       alu1_bypass,
    input  wire  issue_pkg::result_bus_t       alu2_bypass,
    input  wire  issue_pkg::result_bus_t       bru_bypass,
    output issue_pkg::issued_tag_t             iss_tag1,
    output issue_pkg::issued_tag_t             iss_tag2,
    output issue_pkg::issue_to_execute_t       exe1,
    output issue_pkg::issue_to_execute_t       exe2
);
    import issue_pkg::*;

    uop_t  iss1;
    uop_t  iss2;
    data_t rf1_a;
    data_t rf1_b;
    data_t rf2_a;
    data_t rf2_b;
    // index order is forwarding priority
    result_bus_t [4:0] fwd;

    function automatic data_t operand(input phy_tag_t tag, input data_t rf_value,
                                      input result_bus_t [4:0] src);
        data_t value;
        value = rf_value;
        for (int k = 4; k >= 0; k--) begin
            if (src[k].rf_we && src[k].dest == tag) begin
                value = src[k].result;
            end
        end
        if (tag == '0) begin
            value = '0;
        end
        return value;
    endfunction

    function automatic issue_to_execute_t to_exe(input uop_t u, input data_t a,
                                                 input data_t b);
        issue_to_execute_t e;
        e.valid         = u.valid;
        e.rf_we         = u.rf_we;
        e.is_alu1_op    = u.is_alu1_op;
        e.is_br_op      = u.is_br_op;
        e.is_alu2_op    = u.is_alu2_op;
        e.phy_dest      = u.phy_dest;
        e.rob_entry_num = u.rob_entry_num;
        e.src1_value    = a;
        e.src2_value    = b;
        return e;
    endfunction

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            iss1 <= '0;
            iss2 <= '0;
        end else begin
            iss1 <= pick1;
            iss2 <= pick2;
        end
    end

    phys_regfile u_regfile (
        .clk      (clk),
        .raddr1_a (iss1.phy_src1),
        .raddr1_b (iss1.phy_src2),
        .raddr2_a (iss2.phy_src1),
        .raddr2_b (iss2.phy_src2),
        .rdata1_a (rf1_a),
        .rdata1_b (rf1_b),
        .rdata2_a (rf2_a),
        .rdata2_b (rf2_b),
        .we1      (wb1.rf_we),
        .waddr1   (wb1.dest),
        .wdata1   (wb1.result),
        .we2      (wb2.rf_we),
        .waddr2   (wb2.dest),
        .wdata2   (wb2.result)
    );

    // execute bypass ahead of writeback
    assign fwd = {wb2, wb1, bru_bypass, alu2_bypass, alu1_bypass};

    assign exe1 = to_exe(iss1, operand(iss1.phy_src1, rf1_a, fwd),
                         operand(iss1.phy_src2, rf1_b, fwd));
    assign exe2 = to_exe(iss2, operand(iss2.phy_src1, rf2_a, fwd),
                         operand(iss2.phy_src2, rf2_b, fwd));

    assign iss_tag1 = '{valid: iss1.valid && iss1.rf_we, tag: iss1.phy_dest};
    assign iss_tag2 = '{valid: iss2.valid && iss2.rf_we, tag: iss2.phy_dest};

endmodule

`default_nettype wire

// ==== src/issue_select.sv ====
`default_nettype none
`include "issue_cfg.svh"

module issue_select (
    input  wire  issue_pkg::uop_t [`ISSUE_QUEUE_SIZE-1:0] entries,
    output issue_pkg::select_t                            sel1,
    output issue_pkg::select_t                            sel2
);
    import issue_pkg::*;

    logic [`ISSUE_QUEUE_SIZE-1:0] ready;
    logic [`ISSUE_QUEUE_SIZE-1:0] lane1_ok;
    logic [`ISSUE_QUEUE_SIZE-1:0] lane2_ok;

    // lowest set bit wins, slot zero is the oldest
    function automatic select_t oldest(input logic [`ISSUE_QUEUE_SIZE-1:0] req);
        select_t pick;
        pick = '0;
        for (int i = `ISSUE_QUEUE_SIZE - 1; i >= 0; i--) begin
            if (req[i]) begin
                pick.valid = 1'b1;
                pick.idx   = iq_index_t'(i);
            end
        end
        return pick;
    endfunction

    always_comb begin
        for (int i = 0; i < `ISSUE_QUEUE_SIZE; i++) begin
            ready[i] = entries[i].valid
                       && entries[i].src1_ready
                       && entries[i].src2_ready;
            // class bits are one-hot so the lanes never overlap
            lane1_ok[i] = ready[i] && (entries[i].is_alu1_op || entries[i].is_br_op);
            lane2_ok[i] = ready[i] && entries[i].is_alu2_op;
        end
    end

    assign sel1 = oldest(lane1_ok);
    assign sel2 = oldest(lane2_ok);

endmodule

`default_nettype wire

// ==== src/issue_queue.sv ====
`default_nettype none
`include "issue_cfg.svh"

module issue_queue (
    input  wire                                      clk,
    input  wire                                      reset,
    input  wire                                      flush,
    input  wire  issue_pkg::uop_t                    dec_uop1,
    input  wire  issue_pkg::uop_t                    dec_uop2,
    input  wire  issue_pkg::select_t                 sel1,
    input  wire  issue_pkg::select_t                 sel2,
    input  wire  issue_pkg::issued_tag_t             iss_tag1,
    input  wire  issue_pkg::issued_tag_t             iss_tag2,
    input  wire  issue_pkg::result_bus_t             wb1,
    input  wire  issue_pkg::result_bus_t             wb2,
    output logic                                     allowin,
    output issue_pkg::uop_t [`ISSUE_QUEUE_SIZE-1:0]  entries,
    output issue_pkg::uop_t                          pick1,
    output issue_pkg::uop_t                          pick2
);
    import issue_pkg::*;

    localparam int DEPTH = `ISSUE_QUEUE_SIZE;
    localparam int CNT_W = $clog2(`ISSUE_QUEUE_SIZE) + 1;

    uop_t [DEPTH-1:0] queue;
    uop_t [DEPTH-1:0] woken;
    uop_t [DEPTH-1:0] queue_next;
    logic [CNT_W-1:0] count;
    logic [CNT_W-1:0] count_next;
    logic [CNT_W-1:0] tail;
    logic [1:0]       picked_num;
    logic             take1;
    logic             take2;
    logic [DEPTH-1:0] keep;
    logic [1:0]       shift [DEPTH];
    issued_tag_t [5:0] wake;

    // room for two more keeps decode from ever overrunning
    assign allowin = count <= CNT_W'(DEPTH - 2);
    assign entries = queue;

    always_comb begin
        pick1 = queue[sel1.idx];
        pick1.valid = sel1.valid;
        pick2 = queue[sel2.idx];
        pick2.valid = sel2.valid;
    end

    // tags that set ready bits at the coming edge
    always_comb begin
        wake[0] = '{valid: wb1.rf_we, tag: wb1.dest};
        wake[1] = '{valid: wb2.rf_we, tag: wb2.dest};
        wake[2] = '{valid: pick1.valid && pick1.rf_we, tag: pick1.phy_dest};
        wake[3] = '{valid: pick2.valid && pick2.rf_we, tag: pick2.phy_dest};
        wake[4] = iss_tag1;
        wake[5] = iss_tag2;
    end

    always_comb begin
        for (int i = 0; i < DEPTH; i++) begin
            woken[i] = queue[i];
            for (int w = 0; w < 6; w++) begin
                if (wake[w].valid && wake[w].tag == queue[i].phy_src1) begin
                    woken[i].src1_ready = 1'b1;
                end
                if (wake[w].valid && wake[w].tag == queue[i].phy_src2) begin
                    woken[i].src2_ready = 1'b1;
                end
            end
        end
    end

    // survivors slide down past the picked slots below them
    always_comb begin
        for (int k = 0; k < DEPTH; k++) begin
            keep[k] = queue[k].valid
                      && !(sel1.valid && sel1.idx == iq_index_t'(k))
                      && !(sel2.valid && sel2.idx == iq_index_t'(k));
            shift[k] = 2'(sel1.valid && sel1.idx < iq_index_t'(k))
                     + 2'(sel2.valid && sel2.idx < iq_index_t'(k));
        end
    end

    always_comb begin
        picked_num = 2'(sel1.valid) + 2'(sel2.valid);
        tail       = count - CNT_W'(picked_num);
        take1      = dec_uop1.valid && allowin;
        take2      = dec_uop2.valid && allowin;

        queue_next = '0;
        for (int k = 0; k < DEPTH; k++) begin
            if (keep[k]) begin
                queue_next[iq_index_t'(k) - iq_index_t'(shift[k])] = woken[k];
            end
        end

        // new ops land behind the survivors, not woken this cycle
        if (take1) begin
            queue_next[iq_index_t'(tail)] = dec_uop1;
        end
        if (take2) begin
            queue_next[iq_index_t'(tail + CNT_W'(take1))] = dec_uop2;
        end

        count_next = tail + CNT_W'(take1) + CNT_W'(take2);
    end

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            queue <= '0;
            count <= '0;
        end else begin
            queue <= queue_next;
            count <= count_next;
        end
    end

    count_in_range: assert property (@(posedge clk) disable iff (reset)
        count <= CNT_W'(DEPTH));

    // select must never hand both lanes the same slot
    lanes_distinct: assert property (@(posedge clk) disable iff (reset)
        !(sel1.valid && sel2.valid && sel1.idx == sel2.idx));

endmodule

`default_nettype wire

// ==== src/phys_regfile.sv ====
`default_nettype none
`include "issue_cfg.svh"

module phys_regfile (
    input  wire                        clk,
    input  wire  [`PHY_TAG_WIDTH-1:0]  raddr1_a,
    input  wire  [`PHY_TAG_WIDTH-1:0]  raddr1_b,
    input  wire  [`PHY_TAG_WIDTH-1:0]  raddr2_a,
    input  wire  [`PHY_TAG_WIDTH-1:0]  raddr2_b,
    output logic [`DATA_WIDTH-1:0]     rdata1_a,
    output logic [`DATA_WIDTH-1:0]     rdata1_b,
    output logic [`DATA_WIDTH-1:0]     rdata2_a,
    output logic [`DATA_WIDTH-1:0]     rdata2_b,
    input  wire                        we1,
    input  wire  [`PHY_TAG_WIDTH-1:0]  waddr1,
    input  wire  [`DATA_WIDTH-1:0]     wdata1,
    input  wire                        we2,
    input  wire  [`PHY_TAG_WIDTH-1:0]  waddr2,
    input  wire  [`DATA_WIDTH-1:0]     wdata2
);

    logic [`DATA_WIDTH-1:0] regs [`PHY_REG_NUM];

    // p0 is hardwired zero
    assign rdata1_a = (raddr1_a == '0) ? '0 : regs[raddr1_a];
    assign rdata1_b = (raddr1_b == '0) ? '0 : regs[raddr1_b];
    assign rdata2_a = (raddr2_a == '0) ? '0 : regs[raddr2_a];
    assign rdata2_b = (raddr2_b == '0) ? '0 : regs[raddr2_b];

    always_ff @(posedge clk) begin
        if (we1 && waddr1 != '0) begin
            regs[waddr1] <= wdata1;
        end
        if (we2 && waddr2 != '0) begin
            regs[waddr2] <= wdata2;
        end
    end

    // rename hands out each destination to one producer only
    no_write_clash: assert property (@(posedge clk)
        !(we1 && we2 && waddr1 == waddr2 && waddr1 != '0));

endmodule

`default_nettype wire

// ==== src/issue_pkg.sv ====
`default_nettype none
`include "issue_cfg.svh"

package issue_pkg;

    typedef logic [`PHY_TAG_WIDTH-1:0] phy_tag_t;
    typedef logic [`DATA_WIDTH-1:0] data_t;
    typedef logic [$clog2(`ISSUE_QUEUE_SIZE)-1:0] iq_index_t;

    // renamed micro-op, also the queue entry
    typedef struct packed {
        logic                      valid;
        logic                      rf_we;
        logic                      is_alu1_op;
        logic                      is_br_op;
        logic                      is_alu2_op;
        phy_tag_t                  phy_src1;
        phy_tag_t                  phy_src2;
        phy_tag_t                  phy_dest;
        logic [`ROB_TAG_WIDTH-1:0] rob_entry_num;
        logic                      src1_ready;
        logic                      src2_ready;
    } uop_t;

    typedef struct packed {
        logic      valid;
        iq_index_t idx;
    } select_t;

    // bypass and writeback share this layout
    typedef struct packed {
        logic     rf_we;
        phy_tag_t dest;
        data_t    result;
    } result_bus_t;

    typedef struct packed {
        logic                      valid;
        logic                      rf_we;
        logic                      is_alu1_op;
        logic                      is_br_op;
        logic                      is_alu2_op;
        phy_tag_t                  phy_dest;
        logic [`ROB_TAG_WIDTH-1:0] rob_entry_num;
        data_t                     src1_value;
        data_t                     src2_value;
    } issue_to_execute_t;

    typedef struct packed {
        logic     valid;
        phy_tag_t tag;
    } issued_tag_t;

endpackage

`default_nettype wire

// ==== src/issue_cfg.svh ====
`ifndef ISSUE_CFG_SVH
`define ISSUE_CFG_SVH

// issue queue depth
`define ISSUE_QUEUE_SIZE 8

// physical register file
`define PHY_REG_NUM 64
`define PHY_TAG_WIDTH 6

// datapath width
`define DATA_WIDTH 32

// reorder buffer tag carried with each op
`define ROB_TAG_WIDTH 5

`endif
